// File: hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // ------------------------------------------------------------
    // Word and field widths
    // ------------------------------------------------------------

    // Integer input width
    localparam int INT_W = 32;

    // IEEE-754 single precision fields
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;

    // Exponent bias for single precision
    localparam int EXP_BIAS = 127;

    // Leading-zero count width, 0..31 for a nonzero word
    localparam int LZC_W = $clog2(INT_W);

    // ------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------

    // Register stages after the converter, also the valid delay depth
    localparam int CONV_STAGES = 4;

    // ------------------------------------------------------------
    // Float word layout
    // ------------------------------------------------------------

    // Sign, biased exponent, fraction below the hidden one
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } float32_t;

endpackage

`default_nettype wire

// File: hdl/int_to_float_norm.sv
`timescale 1ns/1ps
`default_nettype none

module int_to_float_norm
    import conv_pkg::*;
(
    input  logic [INT_W-1:0] ival,
    output float32_t         fval
);

    // ------------------------------------------------------------
    // Sign and magnitude
    // ------------------------------------------------------------
    logic             sign;
    logic [INT_W-1:0] abs_val;
    logic             is_zero;

    assign sign = ival[INT_W-1];

    // Two's complement negate for negatives
    // INT_MIN wraps to itself, read as unsigned 2^31
    assign abs_val = sign ? (~ival + 1'b1) : ival;

    assign is_zero = (abs_val == '0);

    // ------------------------------------------------------------
    // Leading zero count
    // ------------------------------------------------------------
    logic [LZC_W-1:0] lzc;

    // Scan upward, highest set bit is the last to write
    always_comb begin
        lzc = '0;
        for (int i = 0; i < INT_W; i++) begin
            if (abs_val[i]) begin
                lzc = LZC_W'(INT_W - 1 - i);
            end
        end
    end

    // ------------------------------------------------------------
    // Normalize and pack
    // ------------------------------------------------------------
    logic [INT_W-1:0]  shifted;
    logic [EXP_W-1:0]  exp_field;
    logic [FRAC_W-1:0] frac_field;

    // Leading one moves to the MSB
    assign shifted = abs_val << lzc;

    // Position of leading one plus bias
    assign exp_field = EXP_W'(INT_W - 1 - int'(lzc) + EXP_BIAS);

    // Bits just below the hidden one, lower bits dropped
    assign frac_field = shifted[INT_W-2 -: FRAC_W];

    always_comb begin
        if (is_zero) begin
            // Zero maps to +0.0
            fval = '0;
        end else begin
            fval.sign = sign;
            fval.exp  = exp_field;
            fval.frac = frac_field;
        end
    end

endmodule

`default_nettype wire

// File: hdl/delay_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module delay_buffer
    import conv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  logic enable,
    output logic valid_out
);

    // ------------------------------------------------------------
    // Valid shift register
    // ------------------------------------------------------------

    // Bit k mirrors data pipeline stage k
    logic [CONV_STAGES-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            // New valid enters stage 0
            valid_q[0] <= valid_in;
            // Older bits advance one stage
            for (int k = 1; k < CONV_STAGES; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    // Last stage feeds the output buffer
    assign valid_out = valid_q[CONV_STAGES-1];

endmodule

`default_nettype wire

// File: hdl/oehb.sv
`timescale 1ns/1ps
`default_nettype none

module oehb
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  float32_t ins,
    input  logic     ins_valid,
    output logic     ins_ready,
    output float32_t outs,
    output logic     outs_valid,
    input  logic     outs_ready
);

    // ------------------------------------------------------------
    // Slot state
    // ------------------------------------------------------------
    logic     full_q;
    float32_t data_q;

    // Room when empty or the held word leaves now
    assign ins_ready = ~full_q | outs_ready;

    // Full bit
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (ins_ready) begin
            // Slot is free this edge, so it holds whatever arrives
            full_q <= ins_valid;
        end
    end

    // Payload register, loads on input transfer only
    always_ff @(posedge clk) begin
        if (ins_valid && ins_ready) begin
            data_q <= ins;
        end
    end

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------
    assign outs       = data_q;
    assign outs_valid = full_q;

endmodule

`default_nettype wire

// File: hdl/tehb.sv
`timescale 1ns/1ps
`default_nettype none

module tehb
    import conv_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    output logic             ins_ready,
    output logic [INT_W-1:0] outs,
    output logic             outs_valid,
    input  logic             outs_ready
);

    // ------------------------------------------------------------
    // Slot state
    // ------------------------------------------------------------
    logic             full_q;
    logic [INT_W-1:0] data_q;
    logic             capture;

    // Word arrives while consumer stalls and slot is empty
    assign capture = ins_valid & ~full_q & ~outs_ready;

    // Full bit
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (full_q && outs_ready) begin
            // Stored word handed on
            full_q <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= ins;
        end
    end

    // ------------------------------------------------------------
    // Channel outputs
    // ------------------------------------------------------------

    // Stored word has priority over the input
    assign outs       = full_q ? data_q : ins;
    assign outs_valid = full_q | ins_valid;

    // Input blocked until the stored word drains
    assign ins_ready = ~full_q;

endmodule

`default_nettype wire

// File: hdl/sitofp.sv
`timescale 1ns/1ps
`default_nettype none

module sitofp
    import conv_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    output logic             ins_ready,
    output float32_t         outs,
    output logic             outs_valid,
    input  logic             outs_ready
);

    // ------------------------------------------------------------
    // Conversion
    // ------------------------------------------------------------
    float32_t converted;

    int_to_float_norm norm_i (
        .ival (ins),
        .fval (converted)
    );

    // ------------------------------------------------------------
    // Data pipeline
    // ------------------------------------------------------------
    float32_t pipe_q [CONV_STAGES];
    logic     oehb_ready;
    logic     buff_valid;

    // All stages move together, frozen while oehb is blocked
    always_ff @(posedge clk) begin
        if (oehb_ready) begin
            pipe_q[0] <= converted;
            for (int k = 1; k < CONV_STAGES; k++) begin
                pipe_q[k] <= pipe_q[k-1];
            end
        end
    end

    // ------------------------------------------------------------
    // Valid tracking
    // ------------------------------------------------------------

    // Same enable as the data stages, so valid stays aligned
    delay_buffer delay_buffer_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (ins_valid),
        .enable    (oehb_ready),
        .valid_out (buff_valid)
    );

    // ------------------------------------------------------------
    // Output buffer
    // ------------------------------------------------------------
    oehb oehb_i (
        .clk        (clk),
        .rst        (rst),
        .ins        (pipe_q[CONV_STAGES-1]),
        .ins_valid  (buff_valid),
        .ins_ready  (oehb_ready),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

    // Accept whenever the pipeline can advance
    assign ins_ready = oehb_ready;

endmodule

`default_nettype wire

// File: hdl/sitofp_top.sv
`timescale 1ns/1ps
`default_nettype none

module sitofp_top
    import conv_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    output logic             ins_ready,
    output float32_t         outs,
    output logic             outs_valid,
    input  logic             outs_ready
);

    // ------------------------------------------------------------
    // Inner channel, tehb to sitofp
    // ------------------------------------------------------------
    logic [INT_W-1:0] word;
    logic             word_valid;
    logic             word_ready;

    // Input slot, keeps ins_ready off the pipeline stall path
    tehb tehb_i (
        .clk        (clk),
        .rst        (rst),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .outs       (word),
        .outs_valid (word_valid),
        .outs_ready (word_ready)
    );

    // Conversion pipeline with output slot
    sitofp sitofp_i (
        .clk        (clk),
        .rst        (rst),
        .ins        (word),
        .ins_valid  (word_valid),
        .ins_ready  (word_ready),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

endmodule

`default_nettype wire

// File: testbench/sitofp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sitofp_checker
    import conv_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [INT_W-1:0] ins,
    input  logic             ins_valid,
    input  logic             ins_ready,
    input  float32_t         outs,
    input  logic             outs_valid,
    input  logic             outs_ready,
    input  logic             lat_chk,
    input  logic             stall_active,
    output int               ok_cnt,
    output int               err_cnt,
    output int               pending,
    output logic             blocked_seen
);

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Find the top set bit by halving, then truncate below the hidden one
    function automatic float32_t expected_float(input int v);
        logic [63:0] mag;
        logic [63:0] m;
        logic [63:0] frac;
        int          msb;
        float32_t    f;
        f = '0;
        if (v != 0) begin
            mag = (v < 0) ? 64'(-longint'(v)) : 64'(longint'(v));
            m = mag;
            msb = -1;
            while (m != 0) begin
                m = m >> 1;
                msb++;
            end
            if (msb >= FRAC_W) begin
                frac = mag >> (msb - FRAC_W);
            end else begin
                frac = mag << (FRAC_W - msb);
            end
            f.sign = (v < 0);
            f.exp  = EXP_W'(msb + EXP_BIAS);
            f.frac = frac[FRAC_W-1:0];
        end
        return f;
    endfunction

    // ------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------
    float32_t         exp_q [$];
    logic [INT_W-1:0] in_q [$];
    int               t_q [$];
    bit               lat_q [$];
    int               cycle;
    int               test_no;
    logic             rst_q;

    always @(posedge clk) begin : watch
        float32_t         exp_f;
        logic [INT_W-1:0] in_w;
        int               t_in;
        bit               lat;
        if (rst) begin
            rst_q = 1'b1;
            exp_q.delete();
            in_q.delete();
            t_q.delete();
            lat_q.delete();
            cycle = 0;
            test_no = 0;
            ok_cnt = 0;
            err_cnt = 0;
            blocked_seen = 1'b0;
        end else begin
            // First edge out of reset
            if (rst_q) begin
                if (outs_valid !== 1'b0) begin
                    $display("Error at %0t ns: outs_valid = %b, expected 0",
                             $time, outs_valid);
                    err_cnt++;
                end else if (ins_ready !== 1'b1) begin
                    $display("Error at %0t ns: ins_ready = %b, expected 1",
                             $time, ins_ready);
                    err_cnt++;
                end else begin
                    $display("Test reset state ok");
                    ok_cnt++;
                end
            end
            rst_q = 1'b0;
            // Held-high outs_ready never backs up to the input
            if (lat_chk && ins_ready !== 1'b1) begin
                $display("Error at %0t ns: ins_ready = %b, expected 1 under free flow",
                         $time, ins_ready);
                err_cnt++;
            end
            if (stall_active && !ins_ready) begin
                blocked_seen = 1'b1;
            end
            // Accepted word
            if (ins_valid && ins_ready) begin
                exp_q.push_back(expected_float(int'(ins)));
                in_q.push_back(ins);
                t_q.push_back(cycle);
                lat_q.push_back(lat_chk);
            end
            // Delivered word
            if (outs_valid && outs_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output at %0t ns with no accepted word pending", $time);
                    err_cnt++;
                end else begin
                    exp_f = exp_q.pop_front();
                    in_w = in_q.pop_front();
                    t_in = t_q.pop_front();
                    lat = lat_q.pop_front();
                    test_no++;
                    if (outs !== exp_f) begin
                        $display("Error at %0t ns: outs = %h, expected %h (in %h)",
                                 $time, outs, exp_f, in_w);
                        err_cnt++;
                    end else if (lat && (cycle - t_in) != CONV_STAGES + 1) begin
                        // Accept edge to output edge, with the oehb slot
                        $display("Error at %0t ns: latency = %0d, expected %0d",
                                 $time, cycle - t_in, CONV_STAGES + 1);
                        err_cnt++;
                    end else begin
                        $display("Test %0d in=%h out=%h ok", test_no, in_w, outs);
                        ok_cnt++;
                    end
                end
            end
            cycle++;
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// File: testbench/tb_sitofp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sitofp
    import conv_pkg::*;
;

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    localparam int FREE  = 0;
    localparam int RAND  = 1;
    localparam int STALL = 2;

    // Gap below zero picks a random gap
    typedef struct {
        int val;
        int gap;
        int mode;
        bit lat;
        int stall;
    } test_row_t;

    test_row_t rows [$];

    logic             clk;
    logic             rst;
    logic [INT_W-1:0] ins;
    logic             ins_valid;
    logic             ins_ready;
    float32_t         outs;
    logic             outs_valid;
    logic             outs_ready;
    logic             lat_chk;
    logic             stall_active;
    int               bp_mode;
    int               stall_cnt;
    int               ok_cnt;
    int               err_cnt;
    int               pending;
    logic             blocked_seen;

    function automatic void add_row(int val, int gap, int mode, bit lat, int stall);
        test_row_t r;
        r.val = val;
        r.gap = gap;
        r.mode = mode;
        r.lat = lat;
        r.stall = stall;
        rows.push_back(r);
    endfunction

    function automatic void load_table();
        // Isolated words, latency checked
        add_row(0, 8, FREE, 1, 0);
        add_row(1, 8, FREE, 1, 0);
        add_row(-1, 8, FREE, 1, 0);
        add_row(2, 8, FREE, 1, 0);
        add_row(-2, 8, FREE, 1, 0);
        add_row(32'h0000_0400, 8, FREE, 1, 0);
        add_row(32'h0080_0000, 8, FREE, 1, 0);
        add_row(32'h0100_0000, 8, FREE, 1, 0);
        add_row(32'h4000_0000, 8, FREE, 1, 0);
        add_row(32'h7fff_ffff, 8, FREE, 1, 0);
        add_row(32'h8000_0000, 8, FREE, 1, 0);
        // More than 24 significant bits, low bits dropped
        add_row(32'h0100_0001, 8, FREE, 1, 0);
        add_row(32'h7fff_fff5, 8, FREE, 1, 0);
        add_row(-123456789, 8, FREE, 1, 0);
        // Back to back
        add_row(32'h0123_4567, 0, FREE, 1, 0);
        add_row(-77, 0, FREE, 1, 0);
        add_row(1000000007, 0, FREE, 1, 0);
        add_row(32'h8000_0001, 0, FREE, 1, 0);
        add_row(3, 8, FREE, 1, 0);
        // Random gaps and ready
        for (int i = 0; i < 10; i++) begin
            add_row(int'($urandom()), -1, RAND, 0, 0);
        end
        // Long stall fills tehb, pipeline and oehb
        add_row(int'($urandom()), 0, STALL, 0, 30);
        for (int i = 0; i < 8; i++) begin
            add_row(int'($urandom()), 0, STALL, 0, 0);
        end
        add_row(-5, 4, FREE, 0, 0);
    endfunction

    // ------------------------------------------------------------
    // DUT and checker
    // ------------------------------------------------------------
    sitofp_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .outs       (outs),
        .outs_valid (outs_valid),
        .outs_ready (outs_ready)
    );

    sitofp_checker chk_i (
        .clk          (clk),
        .rst          (rst),
        .ins          (ins),
        .ins_valid    (ins_valid),
        .ins_ready    (ins_ready),
        .outs         (outs),
        .outs_valid   (outs_valid),
        .outs_ready   (outs_ready),
        .lat_chk      (lat_chk),
        .stall_active (stall_active),
        .ok_cnt       (ok_cnt),
        .err_cnt      (err_cnt),
        .pending      (pending),
        .blocked_seen (blocked_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Consumer ready, picked at the rising edge and driven on the falling edge
    initial begin
        logic ready_next;
        outs_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (bp_mode == RAND) begin
                ready_next = ($urandom_range(3, 0) != 0);
            end else if (bp_mode == STALL && stall_cnt > 0) begin
                ready_next = 1'b0;
                stall_cnt--;
            end else begin
                ready_next = 1'b1;
            end
            @(negedge clk);
            outs_ready = ready_next;
        end
    end

    // Hold the word until it is taken, then idle for gap cycles
    task automatic send_word(input logic [INT_W-1:0] val, input int gap);
        ins = val;
        ins_valid = 1'b1;
        while (!ins_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        ins_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin
        @(negedge rst);
        repeat (rows.size() * 40 + 200) @(posedge clk);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("=== FAIL ===");
        $finish;
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int gap;
        void'($urandom(41));
        rst = 1'b1;
        ins = '0;
        ins_valid = 1'b0;
        lat_chk = 1'b0;
        stall_active = 1'b0;
        bp_mode = FREE;
        stall_cnt = 0;
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            bp_mode = rows[i].mode;
            lat_chk = rows[i].lat;
            stall_active = (rows[i].mode == STALL);
            if (rows[i].stall > 0) begin
                stall_cnt = rows[i].stall;
            end
            gap = (rows[i].gap < 0) ? int'($urandom_range(3, 0)) : rows[i].gap;
            send_word(rows[i].val, gap);
        end
        bp_mode = FREE;
        lat_chk = 1'b0;
        // Drain whatever is still in flight
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("Passed %0d, failed %0d", ok_cnt, err_cnt);
        if (err_cnt == 0 && blocked_seen) begin
            $display("=== PASS ===");
        end else begin
            if (!blocked_seen) begin
                $display("ins_ready never fell during the long stall");
            end
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/conv_pkg.sv
hdl/int_to_float_norm.sv
hdl/delay_buffer.sv
hdl/oehb.sv
hdl/tehb.sv
hdl/sitofp.sv
hdl/sitofp_top.sv
testbench/sitofp_checker.sv
testbench/tb_sitofp.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_sitofp -f build.f -o sim_sitofp \
    && ./obj_dir/sim_sitofp > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
